//--- rtl/dataMem.sv
`timescale 1ns/100ps

module dataMem (
  input  logic          clk,
  input  logic          arstN,
  input  lsuPkg::memReq memReqIn,
  output logic          dataStall,
  output lsuPkg::memRsp memRsp
);

  lsuPkg::word                   mem [lsuPkg::memWords];
  lsuPkg::memReq                 reqQ;
  lsuPkg::busyCount              busyCnt;
  logic                          pend;
  logic                          accept;
  logic [lsuPkg::memIdxBits-1:0] wordIdx;
  logic [1:0]                    lane;
  lsuPkg::word                   curWord;
  logic [7:0]                    curByte;
  lsuPkg::word                   loadData;
  lsuPkg::word                   mergeWord;
  logic                          isWordOp;
  logic                          misaligned;
  logic                          writeEn;
  logic                          doneQ;
  logic                          misQ;
  lsuPkg::word                   rdataQ;

  ////////////////////
  // busy timing
  ////////////////////

  // a request is taken whenever the memory is not stalling
  assign accept    = (memReqIn.op != lsuPkg::opIdle) && !dataStall;
  assign dataStall = (busyCnt != '0);

  // the access itself happens in the cycle after dataStall falls
  // and done shows up one cycle after that
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busyCnt <= '0;
      pend    <= 1'b0;
      doneQ   <= 1'b0;
    end else begin
      if (accept)         busyCnt <= lsuPkg::busyCount'(lsuPkg::busyCycles);
      else if (dataStall) busyCnt <= busyCnt - 1'b1;
      pend  <= (busyCnt == lsuPkg::busyCount'(1));
      doneQ <= pend;
    end
  end

  ////////////////////
  // width decoding
  ////////////////////

  // addresses wrap at 16 KiB because only the index bits are looked at
  assign wordIdx = reqQ.adr[lsuPkg::memIdxBits+1:2];
  assign lane    = reqQ.adr[1:0];
  assign curWord = mem[wordIdx];
  assign curByte = curWord[{lane, 3'b000} +: 8];

  assign isWordOp = (reqQ.op == lsuPkg::opRead  && reqQ.funct3 == lsuPkg::funct3Lw) ||
                    (reqQ.op == lsuPkg::opWrite && reqQ.funct3 == lsuPkg::funct3Sw);
  assign misaligned = isWordOp && (lane != 2'b00);

  always_comb begin
    loadData = '0;
    if (reqQ.op == lsuPkg::opRead && !misaligned) begin
      case (reqQ.funct3)
        lsuPkg::funct3Lw:  loadData = curWord;
        lsuPkg::funct3Lb:  loadData = {{(lsuPkg::xLen-8){curByte[7]}}, curByte};
        lsuPkg::funct3Lbu: loadData = {{(lsuPkg::xLen-8){1'b0}}, curByte};
        default:           loadData = '0;
      endcase
    end
  end

  // sb only replaces its own lane of the stored word
  always_comb begin
    mergeWord = curWord;
    if (reqQ.funct3 == lsuPkg::funct3Sw) mergeWord = reqQ.wdata;
    else mergeWord[{lane, 3'b000} +: 8] = reqQ.wdata[7:0];
  end

  assign writeEn = pend && !misaligned && (reqQ.op == lsuPkg::opWrite) &&
                   (reqQ.funct3 == lsuPkg::funct3Sw || reqQ.funct3 == lsuPkg::funct3Sb);

  always_ff @(posedge clk) begin
    if (accept) reqQ <= memReqIn;
    if (pend) begin
      rdataQ <= loadData;
      misQ   <= misaligned;
    end
    if (writeEn) mem[wordIdx] <= mergeWord;
  end

  assign memRsp = '{done: doneQ, misaligned: misQ, rdata: rdataQ};

  donePulse: assert property (@(posedge clk) disable iff (!arstN)
    memRsp.done |=> !memRsp.done);

endmodule

//--- rtl/lsuArb.sv
`timescale 1ns/100ps

module lsuArb (
  input  logic           clk,
  input  logic           arstN,
  input  logic           ptwTranslate,
  input  lsuPkg::memReq  ptwReq,
  output logic           ptwReady,
  output lsuPkg::pteWord pteData,
  input  logic           cpuReq,
  input  lsuPkg::memReq  cpuReqPkt,
  output logic           cpuAck,
  output lsuPkg::memRsp  cpuRsp,
  output lsuPkg::memReq  memReqOut,
  input  lsuPkg::memRsp  memRsp,
  input  logic           dataStall
);

  // the walker wins over the CPU but has to wait out an access that the
  // memory is already busy with, which dataStall tells us about
  typedef enum logic [1:0] {
    stateReady,
    statePtwPending,
    statePtwActive
  } arbState;

  arbState       state;
  arbState       nextState;
  logic          selPtw;
  logic          presentPtw;
  logic          presentCpu;
  logic          accept;
  logic          inFlight;
  logic          ownerPtw;
  logic          cpuServed;
  logic          cpuMisaligned;
  lsuPkg::word   cpuRdata;
  lsuPkg::memRsp ptwSide;
  lsuPkg::memRsp cpuSide;

  always_comb begin
    case (state)
      stateReady:
        if (ptwTranslate && dataStall) nextState = statePtwPending;
        else if (ptwTranslate)         nextState = statePtwActive;
        else                           nextState = stateReady;
      statePtwPending:
        nextState = dataStall ? statePtwPending : statePtwActive;
      // only the walker's own done ends its turn
      statePtwActive:
        nextState = ptwSide.done ? stateReady : statePtwActive;
      default:
        nextState = stateReady;
    endcase
  end

  ////////////////////
  // request steering
  ////////////////////

  // one access is outstanding at a time so nothing is presented in flight
  // and a walker access is not started while a CPU ack is still up
  assign selPtw     = (state == statePtwActive);
  assign presentPtw = selPtw && !inFlight && !cpuAck;
  assign presentCpu = (state == stateReady) && !ptwTranslate && cpuReq &&
                      !cpuServed && !inFlight;

  always_comb begin
    memReqOut = '0;
    if (presentPtw)      memReqOut = ptwReq;
    else if (presentCpu) memReqOut = cpuReqPkt;
  end

  assign accept = (memReqOut.op != lsuPkg::opIdle) && !dataStall;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= stateReady;
      inFlight  <= 1'b0;
      ownerPtw  <= 1'b0;
      cpuServed <= 1'b0;
      cpuAck    <= 1'b0;
    end else begin
      state <= nextState;
      if (accept) begin
        inFlight <= 1'b1;
        ownerPtw <= presentPtw;
      end else if (memRsp.done) begin
        inFlight <= 1'b0;
      end
      // served stays set until the CPU drops its request
      cpuServed <= cpuReq && (cpuServed || (accept && presentCpu));
      // ack rises one cycle after done and falls one edge after cpuReq drops
      cpuAck <= cpuAck ? cpuReq : cpuSide.done;
    end
  end

  ////////////////////
  // response steering
  ////////////////////

  // the side that did not issue the access sees an all zero response
  assign ptwSide = ownerPtw ? memRsp : '0;
  assign cpuSide = ownerPtw ? '0 : memRsp;

  assign ptwReady    = ptwSide.done;
  assign pteData.raw = ptwSide.rdata;

  // walker reads may complete while the ack is up so the CPU result is held
  always_ff @(posedge clk) begin
    if (cpuSide.done) begin
      cpuRdata      <= cpuSide.rdata;
      cpuMisaligned <= cpuSide.misaligned;
    end
  end

  assign cpuRsp = '{done: cpuAck, misaligned: cpuMisaligned, rdata: cpuRdata};

  // a request is only offered while the memory is free to take it at once
  presentOnlyWhenOwned: assert property (@(posedge clk) disable iff (!arstN)
    (memReqOut.op != lsuPkg::opIdle) |->
      !dataStall && (state inside {stateReady, statePtwActive}));

  ackExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(cpuAck && ptwReady));

endmodule

//--- rtl/lsuPkg.sv
package lsuPkg;

  ////////////////////
  // sizes
  ////////////////////

  // width of data words and of every address on the load/store path
  localparam int xLen = 32;

  // 16 KiB of word storage so the word index is address bits 13 to 2
  localparam int memWords = 4096;
  localparam int memIdxBits = $clog2(memWords);

  // number of cycles an accepted access keeps dataStall high
  localparam int busyCycles = 2;
  localparam int busyBits = $clog2(busyCycles + 1);

  // the level-1 page table lives at physical page 1
  localparam logic [21:0] rootPpn = 22'd1;

  typedef logic [xLen-1:0] word;
  typedef logic [busyBits-1:0] busyCount;

  ////////////////////
  // access encoding
  ////////////////////

  // operation codes keep the MemRW encoding of the load/store unit
  typedef enum logic [1:0] {
    opIdle  = 2'b00,
    opWrite = 2'b01,
    opRead  = 2'b10
  } memOp;

  // the only funct3 values the data memory honors
  // loads and stores share codes and are told apart by op
  localparam logic [2:0] funct3Lb  = 3'b000;
  localparam logic [2:0] funct3Lw  = 3'b010;
  localparam logic [2:0] funct3Lbu = 3'b100;
  localparam logic [2:0] funct3Sb  = 3'b000;
  localparam logic [2:0] funct3Sw  = 3'b010;

  // one memory access as issued by the CPU port or the walker
  typedef struct packed {
    memOp       op;
    logic [2:0] funct3;
    word        adr;
    word        wdata;
  } memReq;

  // done is a single-cycle pulse at the end of an access
  typedef struct packed {
    logic done;
    logic misaligned;
    word  rdata;
  } memRsp;

  ////////////////////
  // Sv32 page table entry
  ////////////////////

  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pteEntry;

  // the same memory word seen as plain data or as a table entry
  typedef union packed {
    word     raw;
    pteEntry pte;
  } pteWord;

endpackage

//--- rtl/lsuTop.sv
`timescale 1ns/100ps

module lsuTop (
  input  logic          clk,
  input  logic          arstN,
  input  logic          cpuReq,
  input  lsuPkg::memReq cpuReqPkt,
  output logic          cpuAck,
  output lsuPkg::memRsp cpuRsp,
  input  logic          walkReq,
  input  lsuPkg::word   vAdr,
  output logic          walkAck,
  output lsuPkg::word   pAdr,
  output logic          pageFault
);

  ////////////////////
  // internal buses
  ////////////////////

  // walker to arbiter
  logic           ptwTranslate;
  lsuPkg::memReq  ptwReq;
  logic           ptwReady;
  lsuPkg::pteWord pteData;

  // arbiter to data memory
  lsuPkg::memReq  memReqBus;
  lsuPkg::memRsp  memRspBus;
  logic           dataStall;

  pageTableWalker uWalker (
    .clk, .arstN, .walkReq, .vAdr, .walkAck, .pAdr, .pageFault,
    .ptwTranslate, .ptwReq, .ptwReady, .pteData
  );

  lsuArb uArb (
    .clk, .arstN, .ptwTranslate, .ptwReq, .ptwReady, .pteData,
    .cpuReq, .cpuReqPkt, .cpuAck, .cpuRsp,
    .memReqOut(memReqBus), .memRsp(memRspBus), .dataStall
  );

  dataMem uMem (
    .clk, .arstN, .memReqIn(memReqBus), .dataStall, .memRsp(memRspBus)
  );

endmodule

//--- rtl/pageTableWalker.sv
`timescale 1ns/100ps

module pageTableWalker (
  input  logic           clk,
  input  logic           arstN,
  input  logic           walkReq,
  input  lsuPkg::word    vAdr,
  output logic           walkAck,
  output lsuPkg::word    pAdr,
  output logic           pageFault,
  output logic           ptwTranslate,
  output lsuPkg::memReq  ptwReq,
  input  logic           ptwReady,
  input  lsuPkg::pteWord pteData
);

  typedef enum logic [1:0] {
    walkIdle,
    walkLevel1,
    walkLevel0,
    walkDone
  } walkState;

  walkState    state;
  walkState    nextState;
  lsuPkg::word vaQ;
  lsuPkg::word rootAdr;
  lsuPkg::word tblAdr;
  lsuPkg::word leafAdr;
  logic        isValid;
  logic        isLeaf;

  // an entry with R or X set ends the walk, anything else points to a table
  assign isValid = pteData.pte.v;
  assign isLeaf  = pteData.pte.r | pteData.pte.x;

  // level-1 entry address is the root page plus four bytes per vpn1
  assign rootAdr = {lsuPkg::rootPpn[19:0], vaQ[31:22], 2'b00};

  ////////////////////
  // walk sequencing
  ////////////////////

  always_comb begin
    nextState = state;
    case (state)
      walkIdle:   if (walkReq) nextState = walkLevel1;
      walkLevel1: if (ptwReady) nextState = (!isValid || isLeaf) ? walkDone : walkLevel0;
      walkLevel0: if (ptwReady) nextState = walkDone;
      // hold the answer until the requester lets go of walkReq
      walkDone:   if (!walkReq) nextState = walkIdle;
      default:    nextState = walkIdle;
    endcase
  end

  // the physical address is 34 bits in Sv32 and the top two ppn1 bits
  // do not fit on this 32 bit bus, so they are dropped here
  always_comb begin
    leafAdr = '0;
    if (isValid && state == walkLevel1) begin
      // superpage keeps vpn0 and the offset from the virtual address
      leafAdr = {pteData.pte.ppn1[9:0], vaQ[21:0]};
    end else if (isValid && isLeaf) begin
      leafAdr = {pteData.pte.ppn1[9:0], pteData.pte.ppn0, vaQ[11:0]};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= walkIdle;
      pageFault <= 1'b0;
    end else begin
      state <= nextState;
      if (ptwReady && state == walkLevel1) begin
        pageFault <= !isValid;
      end else if (ptwReady && state == walkLevel0) begin
        // only a leaf is legal at the last level
        pageFault <= !(isValid && isLeaf);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == walkIdle && walkReq) vaQ <= vAdr;
    if (ptwReady && state == walkLevel1) begin
      tblAdr <= {pteData.pte.ppn1[9:0], pteData.pte.ppn0, vaQ[21:12], 2'b00};
    end
    if (ptwReady && ptwTranslate && nextState == walkDone) pAdr <= leafAdr;
  end

  ////////////////////
  // outputs
  ////////////////////

  assign walkAck      = (state == walkDone);
  assign ptwTranslate = (state == walkLevel1) || (state == walkLevel0);

  // every table read is an lw and the request is held until ptwReady
  always_comb begin
    ptwReq.op     = ptwTranslate ? lsuPkg::opRead : lsuPkg::opIdle;
    ptwReq.funct3 = lsuPkg::funct3Lw;
    ptwReq.adr    = (state == walkLevel1) ? rootAdr : tblAdr;
    ptwReq.wdata  = '0;
  end

  // the answer goes out right after the last table read came back
  walkAckAfterReads: assert property (@(posedge clk) disable iff (!arstN)
    $rose(walkAck) |-> !ptwTranslate && $past(ptwReady));

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module lsuTb \
  -f vlog.f -o lsuSim

# the simulator exits non-zero on failure, the grep below decides the status
simOut=$(./obj_dir/lsuSim || true)
echo "$simOut"

echo "$simOut" | grep -q "^RESULT: PASS$"

//--- tests/lsuTb.sv
`timescale 1ns/100ps

module lsuTb;

  typedef struct packed {
    logic        fault;
    lsuPkg::word pa;
  } walkResult;

  // generous bound on any single handshake, scaled by the memory busy time
  localparam int timeoutCycles = 64 * (lsuPkg::busyCycles + 2);

  logic          clk;
  logic          arstN;
  logic          cpuReq;
  lsuPkg::memReq cpuReqPkt;
  logic          cpuAck;
  lsuPkg::memRsp cpuRsp;
  logic          walkReq;
  lsuPkg::word   vAdr;
  logic          walkAck;
  lsuPkg::word   pAdr;
  logic          pageFault;

  // shadow copy of the data memory, indexed by address bits 13 to 2
  lsuPkg::word   shadow [lsuPkg::memWords];
  lsuPkg::memRsp cpuExpQ [$];
  walkResult     walkExpQ [$];
  logic          cpuAckSeen = 1'b0;
  logic          walkAckSeen = 1'b0;
  logic [31:0]   lfsrState = 32'h0c5935c4;

  lsuTop u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stopWithFail(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      stopWithFail($sformatf("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                             $time, name, got, exp));
    end
  endtask

  ////////////////////
  // random numbers
  ////////////////////

  // taps 32 22 2 1 give a maximal length sequence
  function automatic logic [31:0] randBits(int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  // expected response of one access, stores also update the shadow memory
  function automatic lsuPkg::memRsp refAccess(lsuPkg::memReq req);
    lsuPkg::memRsp rsp;
    logic [11:0]   idx;
    logic [7:0]    b;
    logic          isWord;
    rsp = '0;
    rsp.done = 1'b1;
    idx = req.adr[13:2];
    b = shadow[idx][req.adr[1:0] * 8 +: 8];
    // lw and sw share funct3 so one compare covers both
    isWord = (req.funct3 == lsuPkg::funct3Lw);
    rsp.misaligned = isWord && (req.adr[1:0] != 2'b00);
    if (!rsp.misaligned) begin
      if (req.op == lsuPkg::opWrite && isWord) shadow[idx] = req.wdata;
      else if (req.op == lsuPkg::opWrite) shadow[idx][req.adr[1:0] * 8 +: 8] = req.wdata[7:0];
      else if (isWord) rsp.rdata = shadow[idx];
      else if (req.funct3 == lsuPkg::funct3Lb) rsp.rdata = {{24{b[7]}}, b};
      else rsp.rdata = {24'h0, b};
    end
    return rsp;
  endfunction

  // Sv32 walk over the shadow memory; a fault always comes with pAdr zero
  function automatic walkResult refWalk(lsuPkg::word va);
    walkResult      res;
    lsuPkg::pteWord pte;
    logic [33:0]    ptAdr;
    logic [33:0]    pa;
    res = '{fault: 1'b1, pa: '0};
    ptAdr = {lsuPkg::rootPpn, 12'h000} + {22'h0, va[31:22], 2'b00};
    pte.raw = shadow[ptAdr[13:2]];
    if (pte.pte.v && (pte.pte.r || pte.pte.x)) begin
      // a superpage leaf whose 34 bit address is cut to the 32 bit bus
      pa = {pte.pte.ppn1, va[21:0]};
      res = '{fault: 1'b0, pa: pa[31:0]};
    end else if (pte.pte.v) begin
      ptAdr = {pte.pte.ppn1, pte.pte.ppn0, 12'h000} + {22'h0, va[21:12], 2'b00};
      pte.raw = shadow[ptAdr[13:2]];
      if (pte.pte.v && (pte.pte.r || pte.pte.x)) begin
        pa = {pte.pte.ppn1, pte.pte.ppn0, va[11:0]};
        res = '{fault: 1'b0, pa: pa[31:0]};
      end
    end
    return res;
  endfunction

  function automatic lsuPkg::word makePte(logic [11:0] ppn1, logic [9:0] ppn0,
                                          logic v, logic r, logic x);
    lsuPkg::pteWord p;
    p.raw = '0;
    p.pte.ppn1 = ppn1;
    p.pte.ppn0 = ppn0;
    p.pte.v = v;
    p.pte.r = r;
    p.pte.x = x;
    return p.raw;
  endfunction

  ////////////////////
  // drivers
  ////////////////////

  // one four-phase transfer on the CPU port, expected result queued first
  task automatic cpuAccess(lsuPkg::memOp op, logic [2:0] funct3, lsuPkg::word adr,
                           lsuPkg::word wdata);
    lsuPkg::memReq req;
    int            waited;
    req = '{op: op, funct3: funct3, adr: adr, wdata: wdata};
    cpuExpQ.push_back(refAccess(req));
    @(negedge clk);
    cpuReqPkt = req;
    cpuReq = 1'b1;
    waited = 0;
    while (!cpuAck) begin
      @(negedge clk);
      waited++;
      if (waited > timeoutCycles) stopWithFail("timed out waiting for cpuAck to rise");
    end
    cpuReq = 1'b0;
    cpuReqPkt.op = lsuPkg::opIdle;
    waited = 0;
    while (cpuAck) begin
      @(negedge clk);
      waited++;
      if (waited > timeoutCycles) stopWithFail("timed out waiting for cpuAck to fall");
    end
  endtask

  task automatic translate(lsuPkg::word va);
    int waited;
    walkExpQ.push_back(refWalk(va));
    @(negedge clk);
    vAdr = va;
    walkReq = 1'b1;
    waited = 0;
    while (!walkAck) begin
      @(negedge clk);
      waited++;
      if (waited > timeoutCycles) stopWithFail("timed out waiting for walkAck to rise");
    end
    walkReq = 1'b0;
    waited = 0;
    while (walkAck) begin
      @(negedge clk);
      waited++;
      if (waited > timeoutCycles) stopWithFail("timed out waiting for walkAck to fall");
    end
  endtask

  // results are sampled mid cycle where the registered outputs are settled
  always @(negedge clk) begin : compareAcks
    lsuPkg::memRsp cpuExp;
    walkResult     walkExp;
    if (cpuAck && !cpuAckSeen) begin
      if (cpuExpQ.size() == 0) begin
        stopWithFail("cpuAck rose with no CPU access outstanding");
      end else begin
        cpuExp = cpuExpQ.pop_front();
        check("cpuRsp.done", 64'(cpuRsp.done), 64'(cpuExp.done));
        check("cpuRsp.rdata", 64'(cpuRsp.rdata), 64'(cpuExp.rdata));
        check("cpuRsp.misaligned", 64'(cpuRsp.misaligned), 64'(cpuExp.misaligned));
      end
    end
    if (walkAck && !walkAckSeen) begin
      if (walkExpQ.size() == 0) begin
        stopWithFail("walkAck rose with no translation outstanding");
      end else begin
        walkExp = walkExpQ.pop_front();
        check("pAdr", 64'(pAdr), 64'(walkExp.pa));
        check("pageFault", 64'(pageFault), 64'(walkExp.fault));
      end
    end
    cpuAckSeen = cpuAck;
    walkAckSeen = walkAck;
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    lsuPkg::word adr;
    lsuPkg::word data;
    lsuPkg::word conAdr [3];
    lsuPkg::word conData [3];
    logic [7:0]  byteVal;
    arstN = 1'b0;
    cpuReq = 1'b0;
    cpuReqPkt = '0;
    walkReq = 1'b0;
    vAdr = '0;
    repeat (10) @(negedge clk);
    arstN = 1'b1;

    // word stores read back through an alias that differs above bit 13
    for (int i = 0; i < 8; i++) begin
      adr = randBits(32) & 32'hffff_fffc;
      cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, adr, randBits(32));
      cpuAccess(lsuPkg::opRead, lsuPkg::funct3Lw, {randBits(18), adr[13:0]}, '0);
    end

    // one byte per lane, odd lanes with the sign bit set
    for (int i = 0; i < 4; i++) begin
      adr = randBits(32) & 32'hffff_fffc;
      byteVal = {i[0], 7'(randBits(7))};
      cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, adr, randBits(32));
      cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sb, adr + i, {24'(randBits(24)), byteVal});
      cpuAccess(lsuPkg::opRead, lsuPkg::funct3Lw, adr, '0);
      cpuAccess(lsuPkg::opRead, lsuPkg::funct3Lb, adr + i, '0);
      cpuAccess(lsuPkg::opRead, lsuPkg::funct3Lbu, adr + i, '0);
    end

    // misaligned word accesses must leave the stored word alone
    for (int i = 1; i < 4; i++) begin
      adr = randBits(32) & 32'hffff_fffc;
      cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, adr, randBits(32));
      cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, adr + i, randBits(32));
      cpuAccess(lsuPkg::opRead, lsuPkg::funct3Lw, adr + i, '0);
      cpuAccess(lsuPkg::opRead, lsuPkg::funct3Lw, adr, '0);
    end

    // root table at page 1 and one level-0 table at page 2
    cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, 32'h1004,
              makePte(12'(randBits(12)), 10'h0, 1'b1, 1'b1, 1'b0));
    cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, 32'h1008, makePte(12'h0, 10'd2, 1'b1, 1'b0, 1'b0));
    cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, 32'h100c,
              makePte(12'(randBits(12)), 10'(randBits(10)), 1'b0, 1'b1, 1'b1));
    cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, 32'h2014,
              makePte(12'(randBits(12)), 10'(randBits(10)), 1'b1, 1'b1, 1'b1));
    cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, 32'h2018, makePte(12'h0, 10'd3, 1'b1, 1'b0, 1'b0));
    cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, 32'h201c, makePte(12'h0, 10'd4, 1'b0, 1'b0, 1'b0));

    translate({10'd1, 22'(randBits(22))});
    translate({10'd2, 10'd5, 12'(randBits(12))});
    translate({10'd3, 22'(randBits(22))});
    translate({10'd2, 10'd6, 12'(randBits(12))});
    translate({10'd2, 10'd7, 12'(randBits(12))});

    // CPU traffic stays in the top 4 KiB, away from both tables
    for (int i = 0; i < 3; i++) begin
      conAdr[i] = {18'h0, 2'b11, 10'(randBits(10)), 2'b00};
      conData[i] = randBits(32);
    end
    fork
      begin
        translate({10'd2, 10'd5, 12'(12'h3a5)});
        translate({10'd1, 22'h2a_5a5a});
      end
      begin
        for (int i = 0; i < 3; i++) begin
          cpuAccess(lsuPkg::opWrite, lsuPkg::funct3Sw, conAdr[i], conData[i]);
          cpuAccess(lsuPkg::opRead, lsuPkg::funct3Lw, conAdr[i], '0);
        end
      end
    join

    check("cpuExpQ.size", 64'(cpuExpQ.size()), 64'd0);
    check("walkExpQ.size", 64'(walkExpQ.size()), 64'd0);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- vlog.f
rtl/lsuPkg.sv
rtl/pageTableWalker.sv
rtl/lsuArb.sv
rtl/dataMem.sv
rtl/lsuTop.sv
tests/lsuTb.sv
